//--- xconf.f
src/xconf_pkg.sv
src/xconf_host_port.sv
src/xconf_reg.sv
src/xconf_mem.sv
src/xconf.sv
tb/xconf_assertions.sv
tb/xconf_tb.sv

//--- tb/xconf_tb.sv
`timescale 1ns/100ps

module xconf_tb;

   import xconf_pkg::*;

   localparam int ack_timeout = 50;

   logic        clk;
   logic        rst;
   logic        host_req;
   host_cmd_t   host_cmd;
   logic        host_ack;
   conf_t       conf_out;

   conf_t       model;
   conf_t       model_slots [n_slots];
   logic [31:0] rng_state = 32'h7d44_fc99;
   int          check_errors = 0;
   int          timeout_errors = 0;

   xconf DUT (
      .clk      (clk),
      .rst      (rst),
      .host_req (host_req),
      .host_cmd (host_cmd),
      .host_ack (host_ack),
      .conf_out (conf_out)
   );

   bind xconf xconf_assertions u_assertions (
      .clk           (clk),
      .rst           (rst),
      .host_req      (host_req),
      .host_ack      (host_ack),
      .ctr_wr        (ctr_wr),
      .mem_cmd_valid (mem_cmd_valid),
      .conf_ld       (conf_ld)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // expected word after one host write, straight from the address map
   function automatic conf_t apply_field(input conf_t cur, input logic [conf_addr_w-1:0] a,
                                         input logic [data_w-1:0] v);
      conf_t nxt;
      int    u;
      int    off;
      nxt = cur;
      if (a == conf_clear) begin
         nxt = '0;
      end else if (a >= conf_mem0 && a < conf_mem1 + 7) begin
         u   = (a >= conf_mem1) ? 1 : 0;
         off = int'(a) - ((u == 1) ? int'(conf_mem1) : int'(conf_mem0));
         case (off)
            0: nxt.mem[u].iter = v[addr_w-1:0];
            1: nxt.mem[u].per = v[period_w-1:0];
            2: nxt.mem[u].duty = v[period_w-1:0];
            3: nxt.mem[u].sel = v[n_w-1:0];
            4: nxt.mem[u].start = v[addr_w-1:0];
            5: nxt.mem[u].incr = v[addr_w-1:0];
            default: nxt.mem[u].rvrs = v[0];
         endcase
      end else if (a >= conf_alu0 && a < conf_alu1 + 3) begin
         u   = (a >= conf_alu1) ? 1 : 0;
         off = int'(a) - ((u == 1) ? int'(conf_alu1) : int'(conf_alu0));
         case (off)
            0: nxt.alu[u].sela = v[n_w-1:0];
            1: nxt.alu[u].selb = v[n_w-1:0];
            default: nxt.alu[u].fns = v[alu_fns_w-1:0];
         endcase
      end else if (a >= conf_mul0 && a < conf_mul0 + 3) begin
         off = int'(a) - int'(conf_mul0);
         case (off)
            0: nxt.mul.sela = v[n_w-1:0];
            1: nxt.mul.selb = v[n_w-1:0];
            default: nxt.mul.fns = v[mul_fns_w-1:0];
         endcase
      end
      return nxt;
   endfunction

   task automatic check_conf(input conf_t got, input conf_t exp, input string msg);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s, conf_out %h expected %h", $time, msg, got, exp);
         check_errors++;
      end
   endtask

   task automatic check_ack(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s, host_ack %b expected %b", $time, msg, got, exp);
         check_errors++;
      end
   endtask

   // one four-phase transaction, req optionally held after ack
   task automatic host_write(input host_cmd_t cmd, input int hold);
      int n;
      bit seen;
      @(posedge clk);
      host_cmd <= cmd;
      host_req <= 1'b1;
      seen = 0;
      for (n = 0; n < ack_timeout && !seen; n++) begin
         @(negedge clk);
         seen = host_ack;
      end
      if (!seen) begin
         $display("timeout: host_ack never rose for address %0d", cmd.addr);
         timeout_errors++;
      end
      check_conf(conf_out, model, $sformatf("after ack, address %0d", cmd.addr));
      for (n = 0; n < hold; n++) begin
         @(negedge clk);
         check_ack(host_ack, 1'b1, "req still held");
         check_conf(conf_out, model, "req still held");
      end
      @(posedge clk);
      host_req <= 1'b0;
      // port has not yet sampled req low, so ack stays up one more cycle
      @(negedge clk);
      check_ack(host_ack, 1'b1, "ack dropped before req low was sampled");
      seen = 0;
      for (n = 0; n < ack_timeout && !seen; n++) begin
         @(negedge clk);
         seen = !host_ack;
      end
      if (!seen) begin
         $display("timeout: host_ack never fell after req was released");
         timeout_errors++;
      end
   endtask

   task automatic write_field(input logic [conf_addr_w-1:0] a, input logic [data_w-1:0] v,
                              input int hold);
      host_cmd_t c;
      c.addr     = a;
      c.data.raw = v;
      model      = apply_field(model, a, v);
      host_write(c, hold);
   endtask

   task automatic mem_command(input mem_op_t op, input logic [slot_w-1:0] slot);
      host_cmd_t c;
      c.addr          = conf_mem_cmd;
      c.data          = '0;
      c.data.cmd.op   = op;
      c.data.cmd.slot = slot;
      case (op)
         mem_store: model_slots[slot] = model;
         mem_load: model = model_slots[slot];
         default: ;
      endcase
      host_write(c, 0);
   endtask

   // addresses 2 to 24 cover every field
   task automatic fill_all_fields();
      for (int a = conf_mem0; a <= conf_mul0 + 2; a++) begin
         write_field(a[conf_addr_w-1:0], next_rand(), 0);
      end
   endtask

   task automatic test_reset();
      @(negedge clk);
      check_conf(conf_out, '0, "after reset");
      check_ack(host_ack, 1'b0, "after reset");
   endtask

   task automatic test_field_writes();
      fill_all_fields();
      write_field(6'd25, next_rand(), 0);
      write_field(6'd40, next_rand(), 0);
   endtask

   task automatic test_clear();
      write_field(conf_clear, next_rand(), 0);
      check_conf(conf_out, '0, "clear");
   endtask

   task automatic test_store_load();
      conf_t conf_a;
      conf_t conf_b;
      fill_all_fields();
      conf_a = model;
      mem_command(mem_store, 2'd1);
      fill_all_fields();
      conf_b = model;
      mem_command(mem_store, 2'd2);
      write_field(conf_clear, 32'h0, 0);
      mem_command(mem_load, 2'd1);
      check_conf(conf_out, conf_a, "load slot 1");
      mem_command(mem_load, 2'd2);
      check_conf(conf_out, conf_b, "load slot 2");
      // nop and rsvd must neither store nor load
      mem_command(mem_nop, 2'd0);
      mem_command(mem_rsvd, 2'd3);
      check_conf(conf_out, conf_b, "nop and rsvd");
      mem_command(mem_load, 2'd3);
      check_conf(conf_out, '0, "load untouched slot 3");
   endtask

   task automatic test_handshake();
      write_field(conf_alu1 + fld_fns, next_rand(), 20);
      check_conf(conf_out, model, "after req release");
   endtask

   initial begin
      rst      = 1'b1;
      host_req = 1'b0;
      host_cmd = '0;
      model    = '0;
      for (int i = 0; i < n_slots; i++) begin
         model_slots[i] = '0;
      end
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      test_reset();
      test_field_writes();
      test_clear();
      test_store_load();
      test_handshake();

      repeat (2) @(posedge clk);
      $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- tb/xconf_assertions.sv
`timescale 1ns/100ps

module xconf_assertions (
   input logic clk,
   input logic rst,
   input logic host_req,
   input logic host_ack,
   input logic ctr_wr,
   input logic mem_cmd_valid,
   input logic conf_ld
);

   // internal strobes are single cycle
   property single_pulse(logic sig);
      @(posedge clk) disable iff (rst) sig |=> !sig;
   endproperty

   a_wr_pulse: assert property (single_pulse(ctr_wr))
      else $error("ctr_wr stayed high for more than one cycle");

   a_cmd_pulse: assert property (single_pulse(mem_cmd_valid))
      else $error("mem_cmd_valid stayed high for more than one cycle");

   a_ld_pulse: assert property (single_pulse(conf_ld))
      else $error("conf_ld stayed high for more than one cycle");

   a_wr_ld_excl: assert property (@(posedge clk) disable iff (rst) !(ctr_wr && conf_ld))
      else $error("ctr_wr and conf_ld high in the same cycle");

   // ack only answers a pending request
   a_ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(host_ack) |-> host_req)
      else $error("host_ack rose while host_req was low");

endmodule

//--- src/xconf.sv
`timescale 1ns/100ps

module xconf (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 host_req,
   input  xconf_pkg::host_cmd_t host_cmd,
   output logic                 host_ack,
   output xconf_pkg::conf_t     conf_out
);

   import xconf_pkg::*;

   logic      ctr_wr;
   host_cmd_t ctr_cmd;
   logic      mem_cmd_valid;
   mem_cmd_t  mem_cmd;
   logic      conf_ld;
   conf_t     conf_in;

   xconf_host_port u_host_port (
      .clk           (clk),
      .rst           (rst),
      .host_req      (host_req),
      .host_cmd      (host_cmd),
      .host_ack      (host_ack),
      .ctr_wr        (ctr_wr),
      .ctr_cmd       (ctr_cmd),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd       (mem_cmd)
   );

   xconf_reg u_reg (
      .clk      (clk),
      .rst      (rst),
      .ctr_wr   (ctr_wr),
      .ctr_cmd  (ctr_cmd),
      .conf_ld  (conf_ld),
      .conf_in  (conf_in),
      .conf_out (conf_out)
   );

   // memory snapshots the live word
   xconf_mem u_mem (
      .clk           (clk),
      .rst           (rst),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd       (mem_cmd),
      .conf_cur      (conf_out),
      .conf_ld       (conf_ld),
      .conf_in       (conf_in)
   );

endmodule

//--- src/xconf_mem.sv
`timescale 1ns/100ps

module xconf_mem (
   input  logic                clk,
   input  logic                rst,
   input  logic                mem_cmd_valid,
   input  xconf_pkg::mem_cmd_t mem_cmd,
   input  xconf_pkg::conf_t    conf_cur,
   output logic                conf_ld,
   output xconf_pkg::conf_t    conf_in
);

   import xconf_pkg::*;

   conf_t slot_q [n_slots];
   logic  do_store;
   logic  do_load;

   // nop and rsvd fall through
   assign do_store = mem_cmd_valid && (mem_cmd.op == mem_store);
   assign do_load  = mem_cmd_valid && (mem_cmd.op == mem_load);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < n_slots; i++) begin
            slot_q[i] <= '0;
         end
      end else if (do_store) begin
         slot_q[mem_cmd.slot] <= conf_cur;
      end
   end

   // load strobe to the register, one cycle after the command
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         conf_ld <= 1'b0;
      end else begin
         conf_ld <= do_load;
      end
   end

   always_ff @(posedge clk) begin
      if (do_load) begin
         conf_in <= slot_q[mem_cmd.slot];
      end
   end

endmodule

//--- src/xconf_reg.sv
`timescale 1ns/100ps

module xconf_reg (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 ctr_wr,
   input  xconf_pkg::host_cmd_t ctr_cmd,
   input  logic                 conf_ld,
   input  xconf_pkg::conf_t     conf_in,
   output xconf_pkg::conf_t     conf_out
);

   import xconf_pkg::*;

   conf_t                  conf_q;
   conf_t                  conf_nxt;
   logic [conf_addr_w-1:0] addr;
   logic [data_w-1:0]      raw;

   // address match against unit base plus field offset
   function automatic logic hit(
      input logic [conf_addr_w-1:0] a,
      input logic [conf_addr_w-1:0] base,
      input logic [conf_addr_w-1:0] off
   );
      logic [conf_addr_w-1:0] target;
      target = base + off;
      return (a == target);
   endfunction

   assign addr = ctr_cmd.addr;
   assign raw  = ctr_cmd.data.raw;

   always_comb begin
      conf_nxt = conf_q;

      if (conf_ld) begin
         conf_nxt = conf_in;
      end else if (ctr_wr) begin
         if (addr == conf_clear) begin
            conf_nxt = '0;
         end else begin
            // memory ports
            for (int i = 0; i < n_mem; i++) begin
               if (hit(addr, mem_base[i], mem_iter)) begin
                  conf_nxt.mem[i].iter = raw[addr_w-1:0];
               end
               if (hit(addr, mem_base[i], mem_per)) begin
                  conf_nxt.mem[i].per = raw[period_w-1:0];
               end
               if (hit(addr, mem_base[i], mem_duty)) begin
                  conf_nxt.mem[i].duty = raw[period_w-1:0];
               end
               if (hit(addr, mem_base[i], mem_sel)) begin
                  conf_nxt.mem[i].sel = raw[n_w-1:0];
               end
               if (hit(addr, mem_base[i], mem_start)) begin
                  conf_nxt.mem[i].start = raw[addr_w-1:0];
               end
               if (hit(addr, mem_base[i], mem_incr)) begin
                  conf_nxt.mem[i].incr = raw[addr_w-1:0];
               end
               if (hit(addr, mem_base[i], mem_rvrs)) begin
                  conf_nxt.mem[i].rvrs = raw[0];
               end
            end

            // alus
            for (int i = 0; i < n_alu; i++) begin
               if (hit(addr, alu_base[i], fld_sela)) begin
                  conf_nxt.alu[i].sela = raw[n_w-1:0];
               end
               if (hit(addr, alu_base[i], fld_selb)) begin
                  conf_nxt.alu[i].selb = raw[n_w-1:0];
               end
               if (hit(addr, alu_base[i], fld_fns)) begin
                  conf_nxt.alu[i].fns = raw[alu_fns_w-1:0];
               end
            end

            // single multiplier
            if (hit(addr, conf_mul0, fld_sela)) begin
               conf_nxt.mul.sela = raw[n_w-1:0];
            end
            if (hit(addr, conf_mul0, fld_selb)) begin
               conf_nxt.mul.selb = raw[n_w-1:0];
            end
            if (hit(addr, conf_mul0, fld_fns)) begin
               conf_nxt.mul.fns = raw[mul_fns_w-1:0];
            end
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         conf_q <= '0;
      end else begin
         conf_q <= conf_nxt;
      end
   end

   assign conf_out = conf_q;

endmodule

//--- src/xconf_host_port.sv
`timescale 1ns/100ps

module xconf_host_port (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 host_req,
   input  xconf_pkg::host_cmd_t host_cmd,
   output logic                 host_ack,
   output logic                 ctr_wr,
   output xconf_pkg::host_cmd_t ctr_cmd,
   output logic                 mem_cmd_valid,
   output xconf_pkg::mem_cmd_t  mem_cmd
);

   import xconf_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_issue,
      st_wait,
      st_ack
   } state_t;

   state_t              state;
   logic [wait_w-1:0]   wait_cnt;
   host_cmd_t           cmd_q;
   logic                is_mem;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= st_idle;
         wait_cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (host_req) begin
                  state <= st_issue;
               end
            end
            st_issue: begin
               state    <= st_wait;
               wait_cnt <= '0;
            end
            st_wait: begin
               if (wait_cnt == wait_w'(ack_wait - 1)) begin
                  state <= st_ack;
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            st_ack: begin
               // hold ack until the host lets go
               if (!host_req) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // command is stable while req is high
   always_ff @(posedge clk) begin
      if (state == st_idle && host_req) begin
         cmd_q <= host_cmd;
      end
   end

   assign is_mem = (cmd_q.addr == conf_mem_cmd);

   assign ctr_wr        = (state == st_issue) && !is_mem;
   assign mem_cmd_valid = (state == st_issue) && is_mem;
   assign ctr_cmd       = cmd_q;
   assign mem_cmd       = cmd_q.data.cmd;
   assign host_ack      = (state == st_ack);

endmodule

//--- src/xconf_pkg.sv
package xconf_pkg;

   // data and address widths
   localparam int data_w      = 32;
   localparam int conf_addr_w = 6;
   localparam int addr_w      = 8;
   localparam int period_w    = 4;
   localparam int n_w         = 3;
   localparam int alu_fns_w   = 4;
   localparam int mul_fns_w   = 2;

   // unit counts, tied to the conf_t layout
   localparam int n_mem = 2;
   localparam int n_alu = 2;

   // configuration memory
   localparam int n_slots = 4;
   localparam int slot_w  = 2;

   // host port latency from strobe to ack
   localparam int ack_wait = 2;
   localparam int wait_w   = $clog2(ack_wait + 1);

   // address map
   localparam logic [conf_addr_w-1:0] conf_clear   = 6'd0;
   localparam logic [conf_addr_w-1:0] conf_mem_cmd = 6'd1;
   localparam logic [conf_addr_w-1:0] conf_mem0    = 6'd2;
   localparam logic [conf_addr_w-1:0] conf_mem1    = 6'd9;
   localparam logic [conf_addr_w-1:0] conf_alu0    = 6'd16;
   localparam logic [conf_addr_w-1:0] conf_alu1    = 6'd19;
   localparam logic [conf_addr_w-1:0] conf_mul0    = 6'd22;

   localparam logic [conf_addr_w-1:0] mem_base [n_mem] = '{conf_mem0, conf_mem1};
   localparam logic [conf_addr_w-1:0] alu_base [n_alu] = '{conf_alu0, conf_alu1};

   // memory port field offsets
   localparam logic [conf_addr_w-1:0] mem_iter  = 6'd0;
   localparam logic [conf_addr_w-1:0] mem_per   = 6'd1;
   localparam logic [conf_addr_w-1:0] mem_duty  = 6'd2;
   localparam logic [conf_addr_w-1:0] mem_sel   = 6'd3;
   localparam logic [conf_addr_w-1:0] mem_start = 6'd4;
   localparam logic [conf_addr_w-1:0] mem_incr  = 6'd5;
   localparam logic [conf_addr_w-1:0] mem_rvrs  = 6'd6;

   // alu and mul field offsets
   localparam logic [conf_addr_w-1:0] fld_sela = 6'd0;
   localparam logic [conf_addr_w-1:0] fld_selb = 6'd1;
   localparam logic [conf_addr_w-1:0] fld_fns  = 6'd2;

   typedef struct packed {
      logic [addr_w-1:0]   iter;
      logic [period_w-1:0] per;
      logic [period_w-1:0] duty;
      logic [n_w-1:0]      sel;
      logic [addr_w-1:0]   start;
      logic [addr_w-1:0]   incr;
      logic                rvrs;
   } mem_conf_t;

   typedef struct packed {
      logic [n_w-1:0]       sela;
      logic [n_w-1:0]       selb;
      logic [alu_fns_w-1:0] fns;
   } alu_conf_t;

   typedef struct packed {
      logic [n_w-1:0]       sela;
      logic [n_w-1:0]       selb;
      logic [mul_fns_w-1:0] fns;
   } mul_conf_t;

   // whole configuration word
   typedef struct packed {
      mem_conf_t [n_mem-1:0] mem;
      alu_conf_t [n_alu-1:0] alu;
      mul_conf_t             mul;
   } conf_t;

   typedef enum logic [1:0] {
      mem_nop   = 2'd0,
      mem_store = 2'd1,
      mem_load  = 2'd2,
      mem_rsvd  = 2'd3
   } mem_op_t;

   typedef struct packed {
      logic [data_w-slot_w-3:0] pad;
      logic [slot_w-1:0]        slot;
      mem_op_t                  op;
   } mem_cmd_t;

   // field value or memory command
   typedef union packed {
      logic [data_w-1:0] raw;
      mem_cmd_t          cmd;
   } ctr_word_u;

   typedef struct packed {
      logic [conf_addr_w-1:0] addr;
      ctr_word_u              data;
   } host_cmd_t;

endpackage
